// ==== src/cop_mem_pkg.sv ====
//////////////////////////////
// Coprocessor load/store types
//////////////////////////////

package cop_mem_pkg;

    typedef logic [31:0] word_t;     // Bus word, data and addresses
    typedef logic [3:0]  ben_t;      // Byte lane enables
    typedef logic [1:0]  elem_idx_t; // Gather/scatter element, 0 goes first
    typedef logic [1:0]  wb_sel_t;   // {halfword index, byte index}

    typedef enum logic [3:0] {
        mem_op_lw,
        mem_op_lh,
        mem_op_lb,
        mem_op_sw,
        mem_op_sh,
        mem_op_sb,
        mem_op_gather_b,
        mem_op_gather_h,
        mem_op_scatter_b,
        mem_op_scatter_h
    } mem_op_t;

    localparam int SG_BYTE_ELEMS = 4;
    localparam int SG_HALF_ELEMS = 2;

    function automatic logic op_is_store(mem_op_t op);
        return op inside {mem_op_sw, mem_op_sh, mem_op_sb, mem_op_scatter_b, mem_op_scatter_h};
    endfunction

    function automatic logic op_is_word(mem_op_t op);
        return op inside {mem_op_lw, mem_op_sw};
    endfunction

    function automatic logic op_is_half(mem_op_t op);
        return op inside {mem_op_lh, mem_op_sh, mem_op_gather_h, mem_op_scatter_h};
    endfunction

    function automatic logic op_is_byte(mem_op_t op);
        return op inside {mem_op_lb, mem_op_sb, mem_op_gather_b, mem_op_scatter_b};
    endfunction

    function automatic logic op_is_sg(mem_op_t op);
        return op inside {mem_op_gather_b, mem_op_gather_h, mem_op_scatter_b, mem_op_scatter_h};
    endfunction

    // Index of the final element, 0 for single accesses
    function automatic elem_idx_t sg_last_idx(mem_op_t op);
        if (op inside {mem_op_gather_b, mem_op_scatter_b})
            return elem_idx_t'(SG_BYTE_ELEMS - 1);
        if (op inside {mem_op_gather_h, mem_op_scatter_h})
            return elem_idx_t'(SG_HALF_ELEMS - 1);
        return '0;
    endfunction

    // Element on the bus this cycle, one ahead while a response lands
    function automatic elem_idx_t req_elem_idx(elem_idx_t idx, logic resp_good);
        return idx + elem_idx_t'(resp_good);
    endfunction

endpackage

// ==== src/cop_access_if.sv ====
//////////////////////////////
// Per-access state bundle
//////////////////////////////

`timescale 1ns/100ps

interface cop_access_if import cop_mem_pkg::*; ();

    mem_op_t   op;          // Operation of the current instruction
    elem_idx_t elem_idx;    // Element of the outstanding request
    logic [1:0] addr_lsbs;  // Low address bits of the outstanding request
    logic      misaligned;  // Address of the next request is illegal
    logic      resp_good;   // Response landed without error

    modport ctrl (
        input  op, misaligned,
        output elem_idx, addr_lsbs, resp_good
    );

    modport agen (
        input  op, elem_idx, resp_good,
        output misaligned
    );

    modport lanes (
        input  op, elem_idx, addr_lsbs, resp_good
    );

endinterface

// ==== src/cop_mem_ctrl.sv ====
//////////////////////////////
// Load/store access sequencer
//////////////////////////////

`timescale 1ns/100ps

module cop_mem_ctrl import cop_mem_pkg::*; (
    input  logic       g_clk,
    input  logic       g_resetn,
    input  logic       ivalid,
    input  logic       mem_stall,
    input  logic       mem_error,
    input  logic [1:0] addr_lsbs_in,
    cop_access_if.ctrl acc,
    output logic       mem_cen,
    output logic       idone,
    output logic       addr_error,
    output logic       bus_error
);

    typedef enum logic [1:0] {
        st_idle,
        st_elem_1,
        st_elem_2,
        st_elem_3
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t state_n;
    logic        outstanding;  // Request placed, response still owed
    logic        done_q;       // Finished, waiting for ivalid to drop
    logic [1:0]  addr_lsbs_q;
    logic        active;
    logic        completing;
    logic        last_elem;
    logic        can_issue;

    assign acc.elem_idx  = elem_idx_t'(state);  // State encodes the element
    assign acc.addr_lsbs = addr_lsbs_q;

    assign active        = ivalid && !done_q;
    assign completing    = outstanding && !mem_stall;
    assign acc.resp_good = completing && !mem_error;
    assign bus_error     = completing && mem_error;
    assign last_elem     = acc.elem_idx == sg_last_idx(acc.op);

    // First request, or the next element straight after a good response
    assign can_issue  = active && (!outstanding || (acc.resp_good && !last_elem));
    assign addr_error = can_issue && acc.misaligned;
    assign mem_cen    = (outstanding && mem_stall) || (can_issue && !acc.misaligned);
    assign idone      = addr_error || bus_error || (acc.resp_good && last_elem);

    always_comb begin
        state_n = state;
        case (state)
            st_idle: begin
                if (acc.resp_good && !last_elem)
                    state_n = st_elem_1;
            end
            st_elem_1: begin
                if (acc.resp_good && !last_elem)
                    state_n = st_elem_2;
            end
            st_elem_2: begin
                if (acc.resp_good && !last_elem)
                    state_n = st_elem_3;
            end
            default: begin
                state_n = state;  // Element 3 is always last
            end
        endcase
        if (idone)
            state_n = st_idle;  // Last element or any error
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state       <= st_idle;
            outstanding <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            state       <= state_n;
            outstanding <= mem_cen;
            if (idone)
                done_q <= 1'b1;
            else if (!ivalid)
                done_q <= 1'b0;
        end
    end

    // Low bits of whatever request is on the bus
    always_ff @(posedge g_clk) begin
        if (mem_cen)
            addr_lsbs_q <= addr_lsbs_in;
    end

    a_idone_pulse: assert property (@(posedge g_clk) disable iff (!g_resetn)
        idone |=> !idone);

    a_cen_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        mem_cen ##1 mem_stall |-> mem_cen && !idone && $stable(addr_lsbs_in));

endmodule

// ==== src/cop_mem_agen.sv ====
//////////////////////////////
// Address generator
//////////////////////////////

`timescale 1ns/100ps

module cop_mem_agen import cop_mem_pkg::*; (
    input  word_t      base,
    input  word_t      imm,
    input  word_t      data,
    cop_access_if.agen acc,
    output word_t      addr
);

    elem_idx_t req_idx;
    word_t     offset;
    logic      bad_word;
    logic      bad_half;

    assign req_idx = req_elem_idx(acc.elem_idx, acc.resp_good);

    // Scatter/gather offsets come from the elements of data
    always_comb begin
        if (!op_is_sg(acc.op)) begin
            offset = imm;
        end else if (op_is_byte(acc.op)) begin
            offset = {24'b0, data[{req_idx, 3'b000} +: 8]};
        end else begin
            offset = {16'b0, data[{req_idx[0], 4'b0000} +: 16]};
        end
    end

    assign addr = base + offset;

    assign bad_word       = op_is_word(acc.op) && (addr[1:0] != 2'b00);
    assign bad_half       = op_is_half(acc.op) && addr[0];
    assign acc.misaligned = bad_word || bad_half;

    // Byte accesses can never straddle a word
    always_comb begin
        if (op_is_byte(acc.op))
            a_byte_aligned: assert (!acc.misaligned)
                else $error("misaligned flagged for byte access at %h", addr);
    end

endmodule

// ==== src/cop_mem_lanes.sv ====
//////////////////////////////
// Store and writeback lanes
//////////////////////////////

`timescale 1ns/100ps

module cop_mem_lanes import cop_mem_pkg::*; (
    input  word_t       addr,
    input  word_t       data,
    input  wb_sel_t     wb_sel,
    input  word_t       mem_rdata,
    cop_access_if.lanes acc,
    output logic        mem_wen,
    output word_t       mem_wdata,
    output ben_t        mem_ben,
    output ben_t        rd_ben,
    output word_t       rd_wdata
);

    elem_idx_t   req_idx;
    elem_idx_t   src_idx;    // Source element of the store
    logic [7:0]  st_byte;
    logic [15:0] st_half;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [1:0]  dst_byte;   // Destination byte lane
    logic        dst_half;   // Destination halfword lane
    word_t       wb_data;
    ben_t        wb_ben;

    assign req_idx = req_elem_idx(acc.elem_idx, acc.resp_good);
    assign src_idx = op_is_sg(acc.op) ? req_idx : '0;
    assign st_byte = data[{src_idx, 3'b000} +: 8];
    assign st_half = data[{src_idx[0], 4'b0000} +: 16];
    assign mem_wen = op_is_store(acc.op);

    always_comb begin
        mem_wdata = '0;
        mem_ben   = '0;
        if (mem_wen) begin
            if (op_is_word(acc.op)) begin
                mem_wdata = data;
                mem_ben   = 4'b1111;
            end else if (op_is_half(acc.op)) begin
                mem_wdata = {16'b0, st_half} << {addr[1:0], 3'b000};
                mem_ben   = 4'b0011 << addr[1:0];
            end else begin
                mem_wdata = {24'b0, st_byte} << {addr[1:0], 3'b000};
                mem_ben   = 4'b0001 << addr[1:0];
            end
        end
    end

    always_comb begin
        if (mem_wen)
            a_store_ben: assert (mem_ben != '0)
                else $error("store with no byte enables");
    end

    // Loaded data comes from the lanes of the outstanding request
    assign ld_byte  = mem_rdata[{acc.addr_lsbs, 3'b000} +: 8];
    assign ld_half  = mem_rdata[{acc.addr_lsbs[1], 4'b0000} +: 16];
    assign dst_byte = op_is_sg(acc.op) ? acc.elem_idx : wb_sel;   // Gathers use element k
    assign dst_half = op_is_sg(acc.op) ? acc.elem_idx[0] : wb_sel[1];

    always_comb begin
        wb_data = '0;
        wb_ben  = '0;
        if (!mem_wen) begin
            if (op_is_word(acc.op)) begin
                wb_data = mem_rdata;
                wb_ben  = 4'b1111;
            end else if (op_is_half(acc.op)) begin
                wb_data = {16'b0, ld_half} << {dst_half, 4'b0000};
                wb_ben  = 4'b0011 << {dst_half, 1'b0};
            end else begin
                wb_data = {24'b0, ld_byte} << {dst_byte, 3'b000};
                wb_ben  = 4'b0001 << dst_byte;
            end
        end
    end

    assign rd_ben   = acc.resp_good ? wb_ben : '0;   // Only on good completions
    assign rd_wdata = acc.resp_good ? wb_data : '0;

endmodule

// ==== src/cop_mem_top.sv ====
//////////////////////////////
// Coprocessor load/store unit
//////////////////////////////

`timescale 1ns/100ps

module cop_mem_top import cop_mem_pkg::*; (
    input  logic    g_clk,
    input  logic    g_resetn,
    input  logic    ivalid,
    input  mem_op_t op,
    input  word_t   base,
    input  word_t   data,
    input  word_t   imm,
    input  wb_sel_t wb_sel,
    input  word_t   mem_rdata,
    input  logic    mem_stall,
    input  logic    mem_error,
    output logic    idone,
    output logic    addr_error,
    output logic    bus_error,
    output ben_t    rd_ben,
    output word_t   rd_wdata,
    output logic    mem_cen,
    output logic    mem_wen,
    output word_t   mem_addr,
    output word_t   mem_wdata,
    output ben_t    mem_ben
);

    word_t addr;  // Byte address of the current request

    cop_access_if acc_if ();

    assign acc_if.op = op;
    assign mem_addr  = {addr[31:2], 2'b00};  // Bus sees word addresses only

    cop_mem_ctrl ctrl_i (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .ivalid       (ivalid),
        .mem_stall    (mem_stall),
        .mem_error    (mem_error),
        .addr_lsbs_in (addr[1:0]),
        .acc          (acc_if.ctrl),
        .mem_cen      (mem_cen),
        .idone        (idone),
        .addr_error   (addr_error),
        .bus_error    (bus_error)
    );

    cop_mem_agen agen_i (
        .base (base),
        .imm  (imm),
        .data (data),
        .acc  (acc_if.agen),
        .addr (addr)
    );

    cop_mem_lanes lanes_i (
        .addr      (addr),
        .data      (data),
        .wb_sel    (wb_sel),
        .mem_rdata (mem_rdata),
        .acc       (acc_if.lanes),
        .mem_wen   (mem_wen),
        .mem_wdata (mem_wdata),
        .mem_ben   (mem_ben),
        .rd_ben    (rd_ben),
        .rd_wdata  (rd_wdata)
    );

    // A stalled request keeps its whole payload on the bus
    a_stall_payload: assert property (@(posedge g_clk) disable iff (!g_resetn)
        mem_cen ##1 mem_stall |-> $stable(mem_addr) && $stable(mem_wen)
                                  && $stable(mem_wdata) && $stable(mem_ben));

endmodule

// ==== bench/cop_mem_ram.sv ====
//////////////////////////////
// Behavioral bus memory
//////////////////////////////

`timescale 1ns/100ps

module cop_mem_ram import cop_mem_pkg::*; (
    input  logic  g_clk,
    input  logic  g_resetn,
    input  logic  cen,
    input  logic  wen,
    input  word_t addr,
    input  word_t wdata,
    input  ben_t  ben,
    input  logic  stall_en,   // Allow random stalls
    input  logic  error_en,   // Allow random bus errors
    output word_t rdata,
    output logic  stall,
    output logic  error
);

    word_t  mem [256];    // Backdoor array, word indexed
    logic   pending;      // Request accepted, response owed
    word_t  req_addr;
    word_t  req_wdata;
    logic   req_wen;
    ben_t   req_ben;
    integer seed;

    initial seed = 32'hae8b_ed68;

    assign rdata = pending ? mem[req_addr[9:2]] : '0;

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            pending <= 1'b0;
            stall   <= 1'b0;
            error   <= 1'b0;
        end else begin
            // Writes land only on a good completion
            if (pending && !stall && !error && req_wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_ben[b])
                        mem[req_addr[9:2]][8*b +: 8] = req_wdata[8*b +: 8];
                end
            end
            pending <= cen;
            if (cen) begin
                req_addr  <= addr;
                req_wdata <= wdata;
                req_wen   <= wen;
                req_ben   <= ben;
            end
            stall <= cen && stall_en && (($random(seed) % 4) == 0);
            error <= cen && error_en && (($random(seed) % 8) == 0);  // Seen only at completion
        end
    end

endmodule

// ==== bench/cop_mem_tb.sv ====
//////////////////////////////
// Load/store unit testbench
//////////////////////////////

`timescale 1ns/100ps

module cop_mem_tb import cop_mem_pkg::*; ();

    localparam int NUM_TESTS = 200;

    logic    g_clk;
    logic    g_resetn;
    logic    ivalid;
    mem_op_t op;
    word_t   base;
    word_t   data;
    word_t   imm;
    wb_sel_t wb_sel;
    logic    stall_en;
    logic    error_en;
    word_t   mem_rdata;
    logic    mem_stall;
    logic    mem_error;
    logic    idone;
    logic    addr_error;
    logic    bus_error;
    ben_t    rd_ben;
    word_t   rd_wdata;
    logic    mem_cen;
    logic    mem_wen;
    word_t   mem_addr;
    word_t   mem_wdata;
    ben_t    mem_ben;

    word_t  mem_snap [256];   // Memory before the instruction
    word_t  exp_mem [256];
    word_t  shadow;           // Writeback merged by lane
    word_t  exp_rd;
    ben_t   lanes_seen;       // Every lane written back so far
    ben_t   exp_ben;
    int     exp_err;          // 0 none, 1 address, 2 bus
    int     exp_cycles;
    int     cyc_cnt;
    int     n_done;
    logic   bus_seen;
    logic   cen_seen;
    int     issued_cnt;
    int     checked_cnt;
    int     error_count;
    integer seed;

    cop_mem_top cop_mem_top_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .ivalid(ivalid), .op(op),
        .base(base), .data(data), .imm(imm), .wb_sel(wb_sel),
        .mem_rdata(mem_rdata), .mem_stall(mem_stall), .mem_error(mem_error),
        .idone(idone), .addr_error(addr_error), .bus_error(bus_error),
        .rd_ben(rd_ben), .rd_wdata(rd_wdata), .mem_cen(mem_cen), .mem_wen(mem_wen),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ben(mem_ben)
    );

    cop_mem_ram ram_i (
        .g_clk(g_clk), .g_resetn(g_resetn), .cen(mem_cen), .wen(mem_wen),
        .addr(mem_addr), .wdata(mem_wdata), .ben(mem_ben), .stall_en(stall_en),
        .error_en(error_en), .rdata(mem_rdata), .stall(mem_stall), .error(mem_error)
    );

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("ERROR at %0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic word_t ben_mask(input ben_t b);
        return {{8{b[3]}}, {8{b[2]}}, {8{b[1]}}, {8{b[0]}}};
    endfunction

    // Expected writeback, lanes, memory, error and latency of one instruction
    function automatic word_t cop_mem_ref(input mem_op_t r_op, input word_t r_base,
                                          input word_t r_data, input word_t r_imm,
                                          input wb_sel_t r_sel, input logic r_bus,
                                          input int r_done, input word_t snap [256],
                                          output word_t r_mem [256], output int r_err,
                                          output int r_cycles, output ben_t r_ben);
        word_t rd;
        word_t off;
        word_t a;
        int    nelem;
        int    lane;
        logic  sg;
        logic  is_b;
        logic  is_h;
        logic  is_st;
        rd       = '0;
        r_ben    = '0;
        r_mem    = snap;
        r_err    = 0;
        sg       = r_op inside {mem_op_gather_b, mem_op_gather_h,
                                mem_op_scatter_b, mem_op_scatter_h};
        is_b     = r_op inside {mem_op_lb, mem_op_sb, mem_op_gather_b, mem_op_scatter_b};
        is_h     = r_op inside {mem_op_lh, mem_op_sh, mem_op_gather_h, mem_op_scatter_h};
        is_st    = r_op inside {mem_op_sw, mem_op_sh, mem_op_sb,
                                mem_op_scatter_b, mem_op_scatter_h};
        nelem    = !sg ? 1 : (is_b ? SG_BYTE_ELEMS : SG_HALF_ELEMS);
        r_cycles = nelem;
        for (int k = 0; k < nelem; k++) begin
            off = !sg ? r_imm : (is_b ? {24'b0, r_data[8*k +: 8]} : {16'b0, r_data[16*k +: 16]});
            a   = r_base + off;
            if ((!is_b && !is_h && a[1:0] != 2'b00) || (is_h && a[0])) begin
                r_err    = 1;
                r_cycles = k;
                return rd;
            end
            if (r_bus && k == r_done) begin
                r_err    = 2;
                r_cycles = k + 1;
                return rd;
            end
            if (is_st) begin
                if (is_b)
                    r_mem[a[9:2]][8*a[1:0] +: 8] = sg ? r_data[8*k +: 8] : r_data[7:0];
                else if (is_h)
                    r_mem[a[9:2]][16*a[1] +: 16] = sg ? r_data[16*k +: 16] : r_data[15:0];
                else
                    r_mem[a[9:2]] = r_data;
            end else if (is_b) begin
                lane = sg ? k : int'(r_sel);
                rd[8*lane +: 8] = snap[a[9:2]][8*a[1:0] +: 8];
                r_ben[lane] = 1'b1;
            end else if (is_h) begin
                lane = sg ? k : int'(r_sel[1]);
                rd[16*lane +: 16] = snap[a[9:2]][16*a[1] +: 16];
                r_ben[2*lane +: 2] = 2'b11;
            end else begin
                rd    = snap[a[9:2]];
                r_ben = 4'b1111;
            end
        end
        return rd;
    endfunction

    // Comparing process, sampled just before each rising edge
    always @(posedge g_clk) begin
        if (g_resetn && ivalid && checked_cnt != issued_cnt) begin
            if (mem_cen)
                cen_seen = 1'b1;
            if (ram_i.pending && !ram_i.stall) begin
                if (ram_i.error)
                    bus_seen = 1'b1;
                else
                    n_done++;
            end
            shadow     = (shadow & ~ben_mask(rd_ben)) | (rd_wdata & ben_mask(rd_ben));
            lanes_seen = lanes_seen | rd_ben;
            if (idone) begin
                exp_rd = cop_mem_ref(op, base, data, imm, wb_sel, bus_seen, n_done,
                                     mem_snap, exp_mem, exp_err, exp_cycles, exp_ben);
                assert (shadow == exp_rd)
                    else report_mismatch($sformatf("op %s rd %h expected %h",
                                                   op.name(), shadow, exp_rd));
                assert (lanes_seen == exp_ben)
                    else report_mismatch($sformatf("op %s writeback lanes %b expected %b",
                                                   op.name(), lanes_seen, exp_ben));
                assert (addr_error == (exp_err == 1) && bus_error == (exp_err == 2))
                    else report_mismatch($sformatf("op %s error flags %b%b expected type %0d",
                                                   op.name(), addr_error, bus_error, exp_err));
                assert (!(exp_err == 1 && exp_cycles == 0 && cen_seen))
                    else report_mismatch("mem_cen raised on a misaligned access");
                assert (stall_en || cyc_cnt == exp_cycles)
                    else report_mismatch($sformatf("op %s idone after %0d cycles expected %0d",
                                                   op.name(), cyc_cnt, exp_cycles));
                #1;
                for (int i = 0; i < 256; i++) begin
                    assert (ram_i.mem[i] == exp_mem[i])
                        else report_mismatch($sformatf("op %s mem[%0d] %h expected %h",
                                                       op.name(), i, ram_i.mem[i], exp_mem[i]));
                end
                shadow     = '0;
                lanes_seen = '0;
                cyc_cnt    = 0;
                n_done     = 0;
                bus_seen   = 1'b0;
                cen_seen   = 1'b0;
                checked_cnt++;
            end else begin
                cyc_cnt++;
            end
        end
    end

    task automatic fill_memory();
        for (int i = 0; i < 256; i++)
            ram_i.mem[i] = $random(seed);
    endtask

    task automatic run_instr(input mem_op_t t_op, input word_t t_base, input word_t t_data,
                             input word_t t_imm, input wb_sel_t t_sel);
        @(negedge g_clk);
        for (int i = 0; i < 256; i++)
            mem_snap[i] = ram_i.mem[i];
        op     = t_op;
        base   = t_base;
        data   = t_data;
        imm    = t_imm;
        wb_sel = t_sel;
        ivalid = 1'b1;
        issued_cnt++;
        wait (checked_cnt == issued_cnt);
        @(negedge g_clk);
        ivalid = 1'b0;
    endtask

    task automatic run_random_mix(input int count);
        mem_op_t r_op;
        word_t   r_data;
        for (int n = 0; n < count; n++) begin
            r_op   = mem_op_t'(($random(seed) & 32'h7fff_ffff) % 10);
            r_data = $random(seed);
            run_instr(r_op, $random(seed) & 32'hffff_fffc,
                      r_op inside {mem_op_gather_h, mem_op_scatter_h} ? r_data & 32'hfffe_fffe
                                                                      : r_data,
                      $random(seed) & 32'h3fc, wb_sel_t'($random(seed)));
        end
    endtask

    initial begin
        seed        = 32'hae8b_ed68;
        g_resetn    = 1'b0;
        ivalid      = 1'b0;
        op          = mem_op_lw;
        base        = '0;
        data        = '0;
        imm         = '0;
        wb_sel      = '0;
        stall_en    = 1'b0;
        error_en    = 1'b0;
        shadow      = '0;
        lanes_seen  = '0;
        cyc_cnt     = 0;
        n_done      = 0;
        bus_seen    = 1'b0;
        cen_seen    = 1'b0;
        issued_cnt  = 0;
        checked_cnt = 0;
        error_count = 0;
        repeat (10) @(negedge g_clk);
        g_resetn = 1'b1;
        fill_memory();
        for (int al = 0; al < 4; al++) begin  // Loads at every alignment and lane
            for (int s = 0; s < 4; s++) begin
                run_instr(mem_op_lb, $random(seed) & 32'hffff_fffc, '0, al, wb_sel_t'(s));
                if (al % 2 == 0)
                    run_instr(mem_op_lh, $random(seed) & 32'hffff_fffc, '0, al, wb_sel_t'(s));
            end
            run_instr(mem_op_lw, $random(seed) & 32'hffff_fffc, '0, 4 * al, wb_sel_t'(al));
        end
        for (int al = 0; al < 4; al++) begin  // Stores
            run_instr(mem_op_sb, $random(seed) & 32'hffff_fffc, $random(seed), al, '0);
            if (al % 2 == 0)
                run_instr(mem_op_sh, $random(seed) & 32'hffff_fffc, $random(seed), al, '0);
            run_instr(mem_op_sw, $random(seed) & 32'hffff_fffc, $random(seed), 4 * al, '0);
        end
        for (int n = 0; n < 8; n++) begin     // Gathers and scatters
            run_instr(mem_op_gather_b, $random(seed), $random(seed), '0, '0);
            run_instr(mem_op_gather_h, $random(seed), $random(seed) & 32'hfffe_fffe, '0, '0);
            run_instr(mem_op_scatter_b, $random(seed), $random(seed), '0, '0);
            run_instr(mem_op_scatter_h, $random(seed), $random(seed) & 32'hfffe_fffe, '0, '0);
        end
        for (int al = 1; al < 4; al++) begin  // Misaligned accesses
            run_instr(mem_op_lw, $random(seed) & 32'hffff_fffc, '0, al, '0);
            run_instr(mem_op_sw, $random(seed) & 32'hffff_fffc, $random(seed), al, '0);
            if (al % 2 == 1) begin
                run_instr(mem_op_lh, $random(seed) & 32'hffff_fffc, '0, al, '0);
                run_instr(mem_op_sh, $random(seed) & 32'hffff_fffc, $random(seed), al, '0);
            end
        end
        run_instr(mem_op_gather_h, 32'h100, 32'h0005_0004, '0, '0);  // Odd second element
        stall_en = 1'b1;
        fill_memory();
        run_random_mix(40);
        stall_en = 1'b0;
        error_en = 1'b1;
        run_random_mix(40);
        error_en = 1'b0;
        repeat (2) @(negedge g_clk);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 20 * 10);
        $display("Timeout: an instruction never completed before the time limit");
        $display("Finished with errors");
        $fatal(1);
    end

endmodule

// ==== sources.f ====
src/cop_mem_pkg.sv
src/cop_access_if.sv
src/cop_mem_ctrl.sv
src/cop_mem_agen.sv
src/cop_mem_lanes.sv
src/cop_mem_top.sv
bench/cop_mem_ram.sv
bench/cop_mem_tb.sv

// ==== Makefile ====
# Verilator build for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= cop_mem_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
